// ==== all.f ====
verilog/credit_pkg.sv
verilog/flit_pkg.sv
verilog/credit_counter.sv
verilog/multi_grant_rr_arb.sv
verilog/credit_sender.sv
verilog/credit_receiver.sv
verilog/credit_link_top.sv
dv/credit_link_asserts.sv
dv/credit_link_tb.sv

// ==== dv/credit_link_asserts.sv ====
`timescale 1ns/1ps
`default_nettype none

// Handshake and credit rules of the sender, checked on every rising edge.
module credit_link_asserts
  import credit_pkg::*;
  import flit_pkg::*;
(
  input logic                 clk,
  input logic                 rst,
  input logic [NUM_FLOWS-1:0] push_valid,
  input logic [NUM_FLOWS-1:0] push_ready,
  input logic [NUM_FLOWS-1:0] pop_valid,
  input logic                 pop_credit,
  input logic [CREDIT_W-1:0]  credit_initial,
  input logic [CREDIT_W-1:0]  credit_count,
  input logic [CREDIT_W-1:0]  credit_available
);

  // --------------------------------------------------------------------------
  // Sender properties
  // --------------------------------------------------------------------------

  // Reset loads the pool size into the counter.
  count_loads_in_reset: assert property (@(posedge clk)
    rst |=> (credit_count == $past(credit_initial)))
    else $error("credit_count did not load credit_initial in reset");

  // A returned credit may be spent at once, but nothing beyond that.
  grants_within_credit: assert property (@(posedge clk) disable iff (rst)
    $countones(pop_valid) <= int'(credit_available) + int'(pop_credit))
    else $error("more flits granted than credits available");

  // The pool never holds more credits than the receiver has slots.
  count_within_pool: assert property (@(posedge clk) disable iff (rst)
    credit_count <= CREDIT_W'(MAX_CREDIT))
    else $error("credit_count is above the pool size");

  // Ready is only offered to flows that are pushing, so every ready lane pops.
  ready_only_on_valid: assert property (@(posedge clk) disable iff (rst)
    (push_ready & ~push_valid) == '0)
    else $error("push_ready is high for a flow that is not pushing");

endmodule : credit_link_asserts

bind credit_sender credit_link_asserts u_asserts (
  .clk              (clk),
  .rst              (rst),
  .push_valid       (push_valid),
  .push_ready       (push_ready),
  .pop_valid        (pop_valid),
  .pop_credit       (pop_credit),
  .credit_initial   (credit_initial),
  .credit_count     (credit_count),
  .credit_available (credit_available)
);

`default_nettype wire

// ==== dv/credit_link_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module credit_link_tb
  import credit_pkg::*;
  import flit_pkg::*;
();

  // Cycle budgets per test. The watchdog limit is their sum.
  localparam int CLK_PERIOD = 8;
  localparam int RESET_CYCLES = 10;
  localparam int TRAFFIC_CYCLES = 400;
  localparam int FILL_CYCLES = 30;
  localparam int WITHHOLD_CYCLES = 200;
  localparam int DRAIN_LIMIT = 40;
  localparam int TOTAL_CYCLES = RESET_CYCLES + TRAFFIC_CYCLES + 2 * FILL_CYCLES
                              + 2 * WITHHOLD_CYCLES + 4 * (DRAIN_LIMIT + 1);

  logic clk = 1'b0;
  logic rst;
  logic [NUM_FLOWS-1:0] push_valid;
  logic [NUM_FLOWS-1:0][PAYLOAD_W-1:0] push_data;
  logic [NUM_FLOWS-1:0] push_ready;
  logic [CREDIT_W-1:0] credit_initial, credit_withhold, credit_count, credit_available;
  logic out_pop, out_valid;
  flit_t out_flit;

  // Reference model: buffer contents, credit count, arbiter pointer, and
  // the credit that comes back to the sender in the current cycle.
  flit_t model_q[$];
  int model_count, model_ptr;
  bit credit_ret;
  logic [NUM_FLOWS-1:0] accepted_mask;
  // Withhold amount that the next cycle puts on the DUT.
  logic [CREDIT_W-1:0] withhold_req;
  integer seed = 32'hca49_7326;
  string test_name;
  int test_errors, total_errors, tests_run, tests_failed, n, total;

  credit_link_top uut (.*);

  always #(CLK_PERIOD / 2) clk = ~clk;

  task automatic report_mismatch(input string what, input int expected, input int actual);
    $display("Fail %s: %s expected %0h actual %0h", test_name, what, expected, actual);
    test_errors++;
  endtask

  task automatic start_test(input string name);
    test_name = name;
    test_errors = 0;
  endtask

  task automatic finish_test();
    tests_run++;
    total_errors += test_errors;
    if (test_errors == 0) begin
      $display("test %s: pass", test_name);
    end else begin
      $display("test %s: %0d mismatches", test_name, test_errors);
      tests_failed++;
    end
  endtask

  // --------------------------------------------------------------------------
  // One link cycle: drive on the falling edge, check, then advance the model
  // --------------------------------------------------------------------------

  // pop_mode 0 never pops, 1 always pops, anything else pops at random.
  task automatic run_cycle(input bit allow_new, input int pop_mode, output int accepted);
    logic [31:0] rnd;
    logic [NUM_FLOWS-1:0] exp_ready;
    flit_t f;
    int avail, allowed, idx, last, granted;
    bit fire;
    @(negedge clk);
    credit_withhold = withhold_req;
    // Flits accepted at the last edge are gone; held ones stay as they are.
    push_valid = push_valid & ~accepted_mask;
    for (int i = 0; i < NUM_FLOWS; i++) begin
      rnd = $random(seed);
      if (!push_valid[i] && allow_new && rnd[1:0] != 2'b00) begin
        push_valid[i] = 1'b1;
        push_data[i] = rnd[31:16];
      end
    end
    rnd = $random(seed);
    out_pop = (pop_mode == 1) || (pop_mode != 0 && rnd[0]);
    #1;
    // Credits spendable now are the unwithheld count plus the return.
    avail = (model_count > int'(credit_withhold)) ? model_count - int'(credit_withhold) : 0;
    allowed = (avail + int'(credit_ret) > NUM_FLOWS) ? NUM_FLOWS : avail + int'(credit_ret);
    exp_ready = '0;
    granted = 0;
    last = model_ptr;
    for (int i = 0; i < NUM_FLOWS; i++) begin
      idx = (model_ptr + i) % NUM_FLOWS;
      if (push_valid[idx] && granted < allowed) begin
        exp_ready[idx] = 1'b1;
        granted++;
        last = idx;
      end
    end
    if (push_ready !== exp_ready) report_mismatch("push_ready", exp_ready, push_ready);
    if (credit_count !== CREDIT_W'(model_count))
      report_mismatch("credit_count", model_count, int'(credit_count));
    if (credit_available !== CREDIT_W'(avail))
      report_mismatch("credit_available", avail, int'(credit_available));
    if (out_valid !== (model_q.size() != 0))
      report_mismatch("out_valid", int'(model_q.size() != 0), int'(out_valid));
    fire = out_pop && model_q.size() != 0;
    if (fire && out_flit !== model_q[0])
      report_mismatch("out_flit", int'(model_q[0]), int'(out_flit));
    if (fire) void'(model_q.pop_front());
    // Same-cycle flits land in the buffer lowest flow first.
    for (int i = 0; i < NUM_FLOWS; i++) begin
      if (exp_ready[i]) begin
        f.flow_id = flow_id_t'(i);
        f.payload = push_data[i];
        model_q.push_back(f);
      end
    end
    accepted_mask = exp_ready;
    model_count = model_count + int'(credit_ret) - granted;
    if (granted > 0) model_ptr = (last + 1) % NUM_FLOWS;
    credit_ret = fire;
    // Handshakes the DUT completed in this cycle.
    accepted = $countones(push_ready & push_valid);
  endtask

  // Pops everything and lets held flits through, then adds one idle cycle
  // so that the last returned credit shows on credit_count.
  task automatic drain_link();
    int guard, cnt;
    guard = 0;
    while ((model_q.size() != 0 || (push_valid & ~accepted_mask) != '0 || credit_ret)
           && guard < DRAIN_LIMIT) begin
      run_cycle(1'b0, 1, cnt);
      guard++;
    end
    if (guard == DRAIN_LIMIT) begin
      $display("Fail %s: the link did not drain within %0d cycles", test_name, DRAIN_LIMIT);
      test_errors++;
    end
    run_cycle(1'b0, 1, cnt);
  endtask

  initial begin
    #(TOTAL_CYCLES * CLK_PERIOD + 200);
    $display("Watchdog expired before all tests completed");
    $display("ERRORS FOUND");
    $finish;
  end

  initial begin
    logic [31:0] rnd;
    rst = 1'b1;
    push_valid = '1;
    push_data = '0;
    credit_initial = CREDIT_W'(MAX_CREDIT);
    credit_withhold = '0;
    withhold_req = '0;
    out_pop = 1'b0;
    accepted_mask = '0;
    model_count = MAX_CREDIT;
    model_ptr = 0;
    credit_ret = 1'b0;

    // Requests are held high in reset to show that none is accepted.
    start_test("reset");
    for (int i = 0; i <= RESET_CYCLES; i++) begin
      if (i < RESET_CYCLES) @(negedge clk);
      else begin
        rst = 1'b0;
        push_valid = '0;
        #1;
      end
      if (push_ready !== '0) report_mismatch("push_ready", 0, int'(push_ready));
      if (out_valid !== 1'b0) report_mismatch("out_valid", 0, int'(out_valid));
      if (credit_count !== credit_initial)
        report_mismatch("credit_count", int'(credit_initial), int'(credit_count));
    end
    finish_test();

    start_test("traffic");
    for (int i = 0; i < TRAFFIC_CYCLES; i++) run_cycle(1'b1, 2, n);
    finish_test();

    // With no pops the buffer must take exactly one flit per credit.
    start_test("backpressure");
    drain_link();
    total = 0;
    for (int i = 0; i < FILL_CYCLES; i++) begin
      run_cycle(1'b1, 0, n);
      total += n;
    end
    if (total != MAX_CREDIT) report_mismatch("flits accepted", MAX_CREDIT, total);
    drain_link();
    if (credit_count !== CREDIT_W'(MAX_CREDIT))
      report_mismatch("credit_count after drain", MAX_CREDIT, int'(credit_count));
    finish_test();

    start_test("withhold_random");
    for (int i = 0; i < WITHHOLD_CYCLES; i++) begin
      if (i % 16 == 0) begin
        rnd = $random(seed);
        withhold_req = rnd[3:0];
      end
      run_cycle(1'b1, 2, n);
    end
    withhold_req = '0;
    finish_test();

    // Full withhold leaves only the returned credit to spend.
    start_test("withhold_full");
    drain_link();
    for (int i = 0; i < FILL_CYCLES; i++) run_cycle(1'b1, 0, n);
    withhold_req = CREDIT_W'(MAX_CREDIT);
    for (int i = 0; i < WITHHOLD_CYCLES; i++) begin
      total = int'(credit_ret);
      run_cycle(1'b1, 2, n);
      if (n > total) report_mismatch("flits accepted under full withhold", total, n);
    end
    withhold_req = '0;
    drain_link();
    finish_test();

    $display("tests run %0d, tests failed %0d, mismatches %0d",
             tests_run, tests_failed, total_errors);
    if (total_errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule : credit_link_tb

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# Build and run the credit link testbench with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f all.f \
  --top-module credit_link_tb -o credit_link_sim

out=$(./obj_dir/credit_link_sim)
echo "$out"

if echo "$out" | grep -qx "NO ERRORS"; then
  exit 0
fi
exit 1

// ==== verilog/credit_counter.sv ====
`timescale 1ns/1ps
`default_nettype none

// Tracks the number of credits the sender may still spend.
module credit_counter
  import credit_pkg::*;
(
  input  logic                clk,
  input  logic                rst,
  // Increment and decrement for this cycle.
  input  credit_update_t      update,
  // Value loaded into the counter while rst is high.
  input  logic [CREDIT_W-1:0] credit_initial,
  // Credits held back from circulation.
  input  logic [CREDIT_W-1:0] credit_withhold,
  // Counter state before this cycle's change.
  output logic [CREDIT_W-1:0] credit_count,
  // Count minus withhold, never below zero.
  output logic [CREDIT_W-1:0] credit_available
);

  // ---------------------------------------------------------------------------
  // Counter state
  // ---------------------------------------------------------------------------

  logic [CREDIT_W-1:0] incr_ext;
  logic [CREDIT_W-1:0] decr_ext;
  logic [CREDIT_W-1:0] count_next;

  // Widen the change fields to the counter width before the arithmetic.
  assign incr_ext = CREDIT_W'(update.incr);
  assign decr_ext = CREDIT_W'(update.decr);

  // The sender never decrements below what it has plus what is returned in
  // the same cycle, so the result stays within 0 to MAX_CREDIT.
  assign count_next = credit_count + incr_ext - decr_ext;

  // Reset loads the initial pool size instead of clearing to zero.
  always_ff @(posedge clk) begin
    if (rst) begin
      credit_count <= credit_initial;
    end else begin
      credit_count <= count_next;
    end
  end

  // ---------------------------------------------------------------------------
  // Availability
  // ---------------------------------------------------------------------------

  // Withheld credits are not spendable. When the withhold amount exceeds
  // the count, the surplus simply means nothing is available.
  always_comb begin
    if (credit_count > credit_withhold) begin
      credit_available = credit_count - credit_withhold;
    end else begin
      credit_available = '0;
    end
  end

endmodule : credit_counter

`default_nettype wire

// ==== verilog/credit_link_top.sv ====
`timescale 1ns/1ps
`default_nettype none

// Sender and receiver joined into one credit link.
module credit_link_top
  import credit_pkg::*;
  import flit_pkg::*;
(
  input  logic                                clk,
  input  logic                                rst,
  input  logic [NUM_FLOWS-1:0]                push_valid,
  input  logic [NUM_FLOWS-1:0][PAYLOAD_W-1:0] push_data,
  output logic [NUM_FLOWS-1:0]                push_ready,
  input  logic [CREDIT_W-1:0]                 credit_initial,
  input  logic [CREDIT_W-1:0]                 credit_withhold,
  output logic [CREDIT_W-1:0]                 credit_count,
  output logic [CREDIT_W-1:0]                 credit_available,
  input  logic                                out_pop,
  output logic                                out_valid,
  output flit_t                               out_flit
);

  // Link wires between the two sides
  logic [NUM_FLOWS-1:0]  pop_valid;
  flit_t [NUM_FLOWS-1:0] pop_flit;
  logic                  pop_credit;

  credit_sender u_sender (
    .clk              (clk),
    .rst              (rst),
    .push_valid       (push_valid),
    .push_data        (push_data),
    .push_ready       (push_ready),
    .pop_valid        (pop_valid),
    .pop_flit         (pop_flit),
    .pop_credit       (pop_credit),
    .credit_initial   (credit_initial),
    .credit_withhold  (credit_withhold),
    .credit_count     (credit_count),
    .credit_available (credit_available)
  );

  credit_receiver u_receiver (
    .clk        (clk),
    .rst        (rst),
    .pop_valid  (pop_valid),
    .pop_flit   (pop_flit),
    .out_pop    (out_pop),
    .out_valid  (out_valid),
    .out_flit   (out_flit),
    .pop_credit (pop_credit)
  );

endmodule : credit_link_top

`default_nettype wire

// ==== verilog/credit_pkg.sv ====
`default_nettype none

// ---------------------------------------------------------------------------
// Credit pool definitions shared by the sender, the counter and the receiver.
// ---------------------------------------------------------------------------

package credit_pkg;

  // Size of the shared credit pool. The receiver buffer holds exactly this
  // many flits, so a sender that respects its credits can never overrun it.
  localparam int MAX_CREDIT = 8;

  // Credit counts run from 0 to MAX_CREDIT inclusive.
  localparam int CREDIT_W = 4;

  // A single cycle can change the count by up to four (one per flow).
  localparam int CHANGE_W = 3;

  // Buffer pointer width. MAX_CREDIT is a power of two, so the pointers
  // wrap on their own.
  localparam int PTR_W = 3;

  // Per-cycle change to the credit counter. Both fields apply in the same
  // cycle, the increment from returned credits and the decrement from flits
  // that were granted.
  typedef struct packed {
    logic [CHANGE_W-1:0] incr;
    logic [CHANGE_W-1:0] decr;
  } credit_update_t;

endpackage : credit_pkg

`default_nettype wire

// ==== verilog/credit_receiver.sv ====
`timescale 1ns/1ps
`default_nettype none

// Receiver side of the credit link.
// Buffers up to MAX_CREDIT flits and hands back one credit per flit the
// consumer pops. Several lanes can write in the same cycle.
module credit_receiver
  import credit_pkg::*;
  import flit_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst,
  // Flits from the sender, one lane per flow.
  input  logic [NUM_FLOWS-1:0]  pop_valid,
  input  flit_t [NUM_FLOWS-1:0] pop_flit,
  // Consumer side.
  input  logic                  out_pop,
  output logic                  out_valid,
  output flit_t                 out_flit,
  // One credit back to the sender per completed pop.
  output logic                  pop_credit
);

  // ---------------------------------------------------------------------------
  // Storage and pointers
  // ---------------------------------------------------------------------------

  flit_t buffer [MAX_CREDIT];

  logic [PTR_W-1:0]                wr_ptr;
  logic [PTR_W-1:0]                rd_ptr;
  logic [CREDIT_W-1:0]             occupancy;
  logic [NUM_FLOWS-1:0][PTR_W-1:0] lane_addr;
  logic [CHANGE_W-1:0]             wr_num;
  logic                            pop_fire;

  // Give each valid lane the next free slot, lowest flow first. Invalid
  // lanes take no slot, so the written flits stay contiguous.
  always_comb begin
    logic [PTR_W-1:0] addr;
    addr   = wr_ptr;
    wr_num = '0;
    for (int i = 0; i < NUM_FLOWS; i++) begin
      lane_addr[i] = addr;
      if (pop_valid[i]) begin
        addr   = addr + PTR_W'(1);
        wr_num = wr_num + CHANGE_W'(1);
      end
    end
  end

  // The sender's credits guarantee a free slot for every valid lane.
  always_ff @(posedge clk) begin
    for (int i = 0; i < NUM_FLOWS; i++) begin
      if (pop_valid[i]) begin
        buffer[lane_addr[i]] <= pop_flit[i];
      end
    end
  end

  // ---------------------------------------------------------------------------
  // Read side
  // ---------------------------------------------------------------------------

  // A pop only counts while there is something to pop.
  assign pop_fire  = out_pop && out_valid;
  assign out_valid = (occupancy != '0);
  assign out_flit  = buffer[rd_ptr];

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      occupancy  <= '0;
      pop_credit <= 1'b0;
    end else begin
      wr_ptr     <= wr_ptr + PTR_W'(wr_num);
      rd_ptr     <= rd_ptr + PTR_W'(pop_fire);
      occupancy  <= occupancy + CREDIT_W'(wr_num) - CREDIT_W'(pop_fire);
      // Credit goes back the cycle after the pop.
      pop_credit <= pop_fire;
    end
  end

endmodule : credit_receiver

`default_nettype wire

// ==== verilog/credit_sender.sv ====
`timescale 1ns/1ps
`default_nettype none

// Sender side of the credit link.
// Turns per-flow ready/valid pushes into flits on the pop side, limited by
// the shared credit pool. Push to pop has no register in between.
module credit_sender
  import credit_pkg::*;
  import flit_pkg::*;
(
  input  logic                                clk,
  input  logic                                rst,
  // Ready/valid push side, one lane per flow.
  input  logic [NUM_FLOWS-1:0]                push_valid,
  input  logic [NUM_FLOWS-1:0][PAYLOAD_W-1:0] push_data,
  output logic [NUM_FLOWS-1:0]                push_ready,
  // Credit/valid pop side toward the receiver.
  output logic [NUM_FLOWS-1:0]                pop_valid,
  output flit_t [NUM_FLOWS-1:0]               pop_flit,
  input  logic                                pop_credit,
  // Credit counter control and status.
  input  logic [CREDIT_W-1:0]                 credit_initial,
  input  logic [CREDIT_W-1:0]                 credit_withhold,
  output logic [CREDIT_W-1:0]                 credit_count,
  output logic [CREDIT_W-1:0]                 credit_available
);

  credit_update_t       update;
  logic [CREDIT_W-1:0]  spendable;
  logic [CHANGE_W-1:0]  grant_allowed;
  logic [CHANGE_W-1:0]  grant_count;
  logic [NUM_FLOWS-1:0] grant;

  // ---------------------------------------------------------------------------
  // Credit counter
  // ---------------------------------------------------------------------------

  // Returned credits add to the pool, granted flits take from it.
  assign update.incr = CHANGE_W'(pop_credit);
  assign update.decr = grant_count;

  credit_counter u_credit_counter (
    .clk              (clk),
    .rst              (rst),
    .update           (update),
    .credit_initial   (credit_initial),
    .credit_withhold  (credit_withhold),
    .credit_count     (credit_count),
    .credit_available (credit_available)
  );

  // ---------------------------------------------------------------------------
  // Arbitration
  // ---------------------------------------------------------------------------

  // A credit coming back this cycle can be spent right away, so it counts
  // toward what the arbiter may hand out. At most one grant per flow.
  assign spendable = credit_available + CREDIT_W'(pop_credit);
  assign grant_allowed = (spendable < CREDIT_W'(NUM_FLOWS)) ?
                         CHANGE_W'(spendable) : CHANGE_W'(NUM_FLOWS);

  multi_grant_rr_arb u_arb (
    .clk           (clk),
    .rst           (rst),
    .request       (push_valid),
    .grant_allowed (grant_allowed),
    .grant         (grant),
    .grant_count   (grant_count)
  );

  // Nothing is accepted while the link is in reset.
  assign push_ready = grant & {NUM_FLOWS{!rst}};

  // ---------------------------------------------------------------------------
  // Pop side
  // ---------------------------------------------------------------------------

  // A lane pops exactly when its push handshake completes.
  assign pop_valid = push_ready & push_valid;

  // Tag each payload with its lane number
  for (genvar i = 0; i < NUM_FLOWS; i++) begin : gen_flit
    assign pop_flit[i].flow_id = flow_id_t'(i);
    assign pop_flit[i].payload = push_data[i];
  end

endmodule : credit_sender

`default_nettype wire

// ==== verilog/flit_pkg.sv ====
`default_nettype none

// ---------------------------------------------------------------------------
// Flit format and flow definitions.
// ---------------------------------------------------------------------------

package flit_pkg;

  // Number of flows sharing the link.
  localparam int NUM_FLOWS = 4;

  // Width of a flow index.
  localparam int FLOW_W = 2;

  // Width of the payload carried by each flit.
  localparam int PAYLOAD_W = 16;

  // Flow index. Arithmetic on this type wraps modulo NUM_FLOWS.
  typedef logic [FLOW_W-1:0] flow_id_t;

  // One flit on the link. The flow id travels with the payload so the
  // consumer can tell the flows apart after they share the buffer.
  typedef struct packed {
    flow_id_t              flow_id;
    logic [PAYLOAD_W-1:0]  payload;
  } flit_t;

endpackage : flit_pkg

`default_nettype wire

// ==== verilog/multi_grant_rr_arb.sv ====
`timescale 1ns/1ps
`default_nettype none

// Round-robin arbiter that may grant several requesters in one cycle.
module multi_grant_rr_arb
  import credit_pkg::*;
  import flit_pkg::*;
(
  input  logic                 clk,
  input  logic                 rst,
  // One request bit per flow.
  input  logic [NUM_FLOWS-1:0] request,
  // Upper bound on the number of grants this cycle.
  input  logic [CHANGE_W-1:0]  grant_allowed,
  // One grant bit per flow, combinational from request.
  output logic [NUM_FLOWS-1:0] grant,
  // Number of bits set in grant.
  output logic [CHANGE_W-1:0]  grant_count
);

  // ---------------------------------------------------------------------------
  // Priority pointer
  // ---------------------------------------------------------------------------

  // Flow that is looked at first in the next scan.
  flow_id_t priority_ptr;
  // Last flow granted in the current scan.
  flow_id_t last_idx;

  // ---------------------------------------------------------------------------
  // Grant scan
  // ---------------------------------------------------------------------------

  // Walk the flows in order starting at the pointer and grant every
  // requester until the allowed count is used up. The index wraps because
  // flow_id_t is exactly as wide as the flow count needs.
  always_comb begin
    flow_id_t idx;
    grant       = '0;
    grant_count = '0;
    last_idx    = priority_ptr;
    for (int i = 0; i < NUM_FLOWS; i++) begin
      idx = priority_ptr + flow_id_t'(i);
      if (request[idx] && (grant_count < grant_allowed)) begin
        grant[idx]  = 1'b1;
        grant_count = grant_count + CHANGE_W'(1);
        last_idx    = idx;
      end
    end
  end

  // After any grant the flow just past the last winner goes first next
  // time. With no grant the order is left alone so nobody loses its turn.
  always_ff @(posedge clk) begin
    if (rst) begin
      priority_ptr <= '0;
    end else if (|grant) begin
      priority_ptr <= last_idx + flow_id_t'(1);
    end
  end

endmodule : multi_grant_rr_arb

`default_nettype wire
